//--- design/boot_rom.sv
`timescale 1ns/100ps
`include "dbus_config.svh"

module boot_rom (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  dbus_pkg::slave_req_t req_i,
    output dbus_pkg::bus_data_t  rdata_o,
    output logic                 stall_o
);

    localparam int CNT_W = $clog2(`ROM_WAIT + 1);

    dbus_pkg::rom_state_t    state_q;
    logic [CNT_W-1:0]        wait_cnt_q;
    logic [`ROM_ADDR_W-1:0]  word_idx;
    logic [15:0]             idx16;

    assign word_idx = req_i.addr[`ROM_ADDR_W+1:2];
    assign idx16    = 16'(word_idx);

    // stall starts in the very first cycle a read shows up.
    assign stall_o = (state_q == dbus_pkg::ROM_WAIT_ST) ||
                     (state_q == dbus_pkg::ROM_IDLE && req_i.read);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= dbus_pkg::ROM_IDLE;
            wait_cnt_q <= '0;
        end else begin
            case (state_q)
                dbus_pkg::ROM_IDLE: begin
                    if (req_i.read) begin
                        wait_cnt_q <= CNT_W'(1);
                        state_q    <= (`ROM_WAIT > 1) ? dbus_pkg::ROM_WAIT_ST : dbus_pkg::ROM_DONE;
                    end
                end
                dbus_pkg::ROM_WAIT_ST: begin
                    wait_cnt_q <= wait_cnt_q + CNT_W'(1);
                    if (wait_cnt_q == CNT_W'(`ROM_WAIT - 1)) state_q <= dbus_pkg::ROM_DONE;
                end
                default: state_q <= dbus_pkg::ROM_IDLE; // the read is accepted here.
            endcase
        end
    end

    // pattern word is ~index in the upper half and index in the lower half.
    always_ff @(posedge clk) begin
        if (state_q == dbus_pkg::ROM_DONE && req_i.read) begin
            rdata_o <= {~idx16, idx16};
        end
    end

    a_stall_len: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(stall_o) |-> ##(`ROM_WAIT) !stall_o);

endmodule

//--- design/data_ram.sv
`timescale 1ns/100ps
`include "dbus_config.svh"

module data_ram (
    input  logic                 clk,
    input  dbus_pkg::slave_req_t req_i,
    output dbus_pkg::bus_data_t  rdata_o
);

    localparam int DEPTH = 1 << `RAM_ADDR_W;

    dbus_pkg::bus_data_t     mem [0:DEPTH-1];
    logic [`RAM_ADDR_W-1:0]  word_idx;

    assign word_idx = req_i.addr[`RAM_ADDR_W+1:2]; // byte address to word index.

    // byte lanes are written on their own so the array maps onto block RAM.
    always_ff @(posedge clk) begin
        if (req_i.write) begin
            for (int b = 0; b < `DBUS_BE_W; b++) begin
                if (req_i.be[b]) begin
                    mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.read) begin
            rdata_o <= mem[word_idx];
        end
    end

endmodule

//--- design/dbus_decoder.sv
`timescale 1ns/100ps
`include "dbus_config.svh"

module dbus_decoder (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  dbus_pkg::bus_addr_t  m_addr_i,
    input  dbus_pkg::bus_data_t  m_wdata_i,
    input  dbus_pkg::byte_en_t   m_be_i,
    input  logic                 m_read_i,
    input  logic                 m_write_i,
    output dbus_pkg::bus_data_t  m_rdata_o,
    output logic                 m_stall_o,
    output dbus_pkg::slave_req_t ram_req_o,
    output dbus_pkg::slave_req_t rom_req_o,
    output dbus_pkg::slave_req_t gpio_req_o,
    output dbus_pkg::slave_req_t tick_req_o,
    input  dbus_pkg::bus_data_t  ram_rdata_i,
    input  dbus_pkg::bus_data_t  rom_rdata_i,
    input  dbus_pkg::bus_data_t  gpio_rdata_i,
    input  dbus_pkg::bus_data_t  tick_rdata_i,
    input  logic                 rom_stall_i
);

    dbus_pkg::slave_sel_t sel;
    dbus_pkg::slave_sel_t rsel_q; // slave of the last accepted read.
    logic                 accept;

    function automatic dbus_pkg::slave_req_t make_req(logic hit);
        dbus_pkg::slave_req_t r;
        r.addr  = m_addr_i;
        r.wdata = m_wdata_i;
        r.be    = m_be_i;
        r.read  = m_read_i && hit;
        r.write = m_write_i && hit;
        return r;
    endfunction

    always_comb begin
        case (m_addr_i[31:28])
            `SEL_RAM:  sel = dbus_pkg::SLV_RAM;
            `SEL_ROM:  sel = dbus_pkg::SLV_ROM;
            `SEL_GPIO: sel = dbus_pkg::SLV_GPIO;
            `SEL_TICK: sel = dbus_pkg::SLV_TICK;
            default:   sel = dbus_pkg::SLV_NONE; // unmapped accesses complete at once.
        endcase
    end

    assign ram_req_o  = make_req(sel == dbus_pkg::SLV_RAM);
    assign rom_req_o  = make_req(sel == dbus_pkg::SLV_ROM);
    assign gpio_req_o = make_req(sel == dbus_pkg::SLV_GPIO);
    assign tick_req_o = make_req(sel == dbus_pkg::SLV_TICK);

    assign m_stall_o = (sel == dbus_pkg::SLV_ROM) && rom_stall_i;
    assign accept    = (m_read_i || m_write_i) && !m_stall_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsel_q <= dbus_pkg::SLV_NONE;
        end else if (accept && m_read_i) begin
            rsel_q <= sel;
        end
    end

    // read data comes back one cycle after acceptance.
    always_comb begin
        case (rsel_q)
            dbus_pkg::SLV_RAM:  m_rdata_o = ram_rdata_i;
            dbus_pkg::SLV_ROM:  m_rdata_o = rom_rdata_i;
            dbus_pkg::SLV_GPIO: m_rdata_o = gpio_rdata_i;
            dbus_pkg::SLV_TICK: m_rdata_o = tick_rdata_i;
            default:            m_rdata_o = '0;
        endcase
    end

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({ram_req_o.read || ram_req_o.write, rom_req_o.read || rom_req_o.write,
                  gpio_req_o.read || gpio_req_o.write, tick_req_o.read || tick_req_o.write}));

endmodule

//--- design/dbus_pkg.sv
`include "dbus_config.svh"

package dbus_pkg;

    typedef logic [31:0]               bus_addr_t;
    typedef logic [`DBUS_DATA_W-1:0]   bus_data_t;
    typedef logic [`DBUS_BE_W-1:0]     byte_en_t;

    typedef enum logic [2:0] {
        SLV_RAM,
        SLV_ROM,
        SLV_GPIO,
        SLV_TICK,
        SLV_NONE
    } slave_sel_t;

    // one request as seen by a single slave.
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        byte_en_t  be;
        logic      read;
        logic      write;
    } slave_req_t;

    typedef enum logic [1:0] {
        ROM_IDLE,
        ROM_WAIT_ST,
        ROM_DONE
    } rom_state_t;

    // replaces the enabled bytes of a register word with new data.
    function automatic bus_data_t merge_bytes(bus_data_t old_w, bus_data_t new_w, byte_en_t be);
        bus_data_t res;
        res = old_w;
        for (int b = 0; b < `DBUS_BE_W; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

endpackage

//--- design/gpio_regs.sv
`timescale 1ns/100ps

module gpio_regs (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  dbus_pkg::slave_req_t req_i,
    output dbus_pkg::bus_data_t  rdata_o,
    input  dbus_pkg::bus_data_t  gpio_in_i,
    output dbus_pkg::bus_data_t  gpio_out_o
);

    dbus_pkg::bus_data_t out_q;
    dbus_pkg::bus_data_t in_meta_q;
    dbus_pkg::bus_data_t in_sync_q;

    assign gpio_out_o = out_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (req_i.write && req_i.addr[3:2] == 2'd0) begin
            out_q <= dbus_pkg::merge_bytes(out_q, req_i.wdata, req_i.be);
        end
    end

    // the input pins are asynchronous to clk.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.read) begin
            case (req_i.addr[3:2])
                2'd0:    rdata_o <= out_q;
                2'd1:    rdata_o <= in_sync_q;
                default: rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- design/soc_dbus_top.sv
`timescale 1ns/100ps

module soc_dbus_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  dbus_pkg::bus_addr_t m_addr_i,
    input  dbus_pkg::bus_data_t m_wdata_i,
    input  dbus_pkg::byte_en_t  m_be_i,
    input  logic                m_read_i,
    input  logic                m_write_i,
    output dbus_pkg::bus_data_t m_rdata_o,
    output logic                m_stall_o,
    input  dbus_pkg::bus_data_t gpio_in_i,
    output dbus_pkg::bus_data_t gpio_out_o,
    output logic                irq_o
);

    dbus_pkg::slave_req_t ram_req, rom_req, gpio_req, tick_req;
    dbus_pkg::bus_data_t  ram_rdata, rom_rdata, gpio_rdata, tick_rdata;
    logic                 rom_stall;

    dbus_decoder dec_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .m_addr_i     (m_addr_i),
        .m_wdata_i    (m_wdata_i),
        .m_be_i       (m_be_i),
        .m_read_i     (m_read_i),
        .m_write_i    (m_write_i),
        .m_rdata_o    (m_rdata_o),
        .m_stall_o    (m_stall_o),
        .ram_req_o    (ram_req),
        .rom_req_o    (rom_req),
        .gpio_req_o   (gpio_req),
        .tick_req_o   (tick_req),
        .ram_rdata_i  (ram_rdata),
        .rom_rdata_i  (rom_rdata),
        .gpio_rdata_i (gpio_rdata),
        .tick_rdata_i (tick_rdata),
        .rom_stall_i  (rom_stall)
    );

    data_ram ram_i (.clk(clk), .req_i(ram_req), .rdata_o(ram_rdata));

    boot_rom rom_i (.clk(clk), .rst_n_i(rst_n_i), .req_i(rom_req), .rdata_o(rom_rdata),
                    .stall_o(rom_stall));

    gpio_regs gpio_i (.clk(clk), .rst_n_i(rst_n_i), .req_i(gpio_req), .rdata_o(gpio_rdata),
                      .gpio_in_i(gpio_in_i), .gpio_out_o(gpio_out_o));

    ticker tick_i (.clk(clk), .rst_n_i(rst_n_i), .req_i(tick_req), .rdata_o(tick_rdata),
                   .irq_o(irq_o));

endmodule

//--- design/ticker.sv
`timescale 1ns/100ps

module ticker (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  dbus_pkg::slave_req_t req_i,
    output dbus_pkg::bus_data_t  rdata_o,
    output logic                 irq_o
);

    dbus_pkg::bus_data_t count_q;
    dbus_pkg::bus_data_t cmp_q;
    logic                irq_q;
    logic [1:0]          reg_idx;

    assign reg_idx = req_i.addr[3:2];
    assign irq_o   = irq_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
        end else begin
            if (req_i.write && reg_idx == 2'd0) begin
                count_q <= dbus_pkg::merge_bytes(count_q, req_i.wdata, req_i.be);
            end else begin
                count_q <= count_q + 1'b1;
            end
            if (req_i.write && reg_idx == 2'd1) begin
                cmp_q <= dbus_pkg::merge_bytes(cmp_q, req_i.wdata, req_i.be);
            end
            // a clear from the bus wins over a match in the same cycle.
            if (req_i.write && reg_idx == 2'd2) irq_q <= 1'b0;
            else if (cmp_q != '0 && count_q == cmp_q) irq_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.read) begin
            case (reg_idx)
                2'd0:    rdata_o <= count_q;
                2'd1:    rdata_o <= cmp_q;
                2'd2:    rdata_o <= {{($bits(rdata_o) - 1){1'b0}}, irq_q};
                default: rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- include/dbus_config.svh
`ifndef DBUS_CONFIG_SVH
`define DBUS_CONFIG_SVH

// data word and byte-enable widths of the data bus.
`define DBUS_DATA_W 32
`define DBUS_BE_W   (`DBUS_DATA_W / 8)

`define RAM_ADDR_W  10 // 1024 words.
`define ROM_ADDR_W  8

// stall cycles the boot ROM inserts in front of every read.
`define ROM_WAIT    3

// address bits 31..28 pick the slave.
`define SEL_RAM     4'h0
`define SEL_ROM     4'h1
`define SEL_GPIO    4'h2
`define SEL_TICK    4'h3

`endif

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
grep -q "Done: no errors" sim.log
echo "simulation passed"

//--- tb.f
+incdir+include
design/dbus_pkg.sv
design/dbus_decoder.sv
design/data_ram.sv
design/boot_rom.sv
design/gpio_regs.sv
design/ticker.sv
design/soc_dbus_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 4 ns period.
    end

    // reset is released 1 ns after the fifth rising edge.
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/100ps
`include "dbus_config.svh"

module tb_top;

    localparam int N_ACCESS        = 100;
    localparam int IRQ_DIST        = 12;
    localparam int WATCHDOG_CYCLES = N_ACCESS * (`ROM_WAIT + 4) + 300;

    logic                clk, rst_n_i, m_read_i, m_write_i, m_stall_o, irq_o;
    dbus_pkg::bus_addr_t m_addr_i;
    dbus_pkg::bus_data_t m_wdata_i, m_rdata_o, gpio_in_i, gpio_out_o, rd, val;
    dbus_pkg::byte_en_t  m_be_i, be;
    dbus_pkg::bus_data_t shadow [1024]; // expected contents of the data RAM.
    logic [9:0]          ram_idx [16];
    int                  errors = 0, checks = 0, cycle = 0, accept_cycle, stalls, t_load;

    tb_clock clk_gen_i (.clk_o(clk), .rst_n_o(rst_n_i));
    soc_dbus_top dut_i (.*);

    always @(posedge clk) cycle <= cycle + 1;

    function automatic dbus_pkg::bus_addr_t slave_addr(logic [3:0] sel, logic [27:0] off);
        return {sel, off};
    endfunction

    function automatic dbus_pkg::bus_addr_t ram_addr(logic [9:0] idx);
        return slave_addr(`SEL_RAM, 28'({idx, 2'b00}));
    endfunction

    task automatic check_value(string name, dbus_pkg::bus_data_t exp, dbus_pkg::bus_data_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // presents one access and returns 1 ns after the edge that accepts it.
    task automatic do_access(dbus_pkg::bus_addr_t addr, dbus_pkg::bus_data_t wdata,
                             dbus_pkg::byte_en_t ben, logic wr);
        m_addr_i  = addr;
        m_wdata_i = wdata;
        m_be_i    = ben;
        m_read_i  = !wr;
        m_write_i = wr;
        stalls    = 0;
        @(negedge clk);
        while (m_stall_o) begin
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        accept_cycle = cycle;
        m_read_i     = 1'b0;
        m_write_i    = 1'b0;
    endtask

    task automatic bus_read(dbus_pkg::bus_addr_t addr);
        do_access(addr, '0, '0, 1'b0);
        @(negedge clk);
        rd = m_rdata_o; // valid in the cycle after acceptance.
        @(posedge clk);
        #1;
    endtask

    a_stall_rom_only: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_stall_o |-> (m_read_i && m_addr_i[31:28] == `SEL_ROM))
        else begin
            errors++;
            $display("stall was raised for an access that is not a ROM read");
        end

    initial begin
        logic [15:0] lo;
        int          waited;
        void'($urandom(32'hc9dd_17a9));
        m_addr_i  = '0;
        m_wdata_i = '0;
        m_be_i    = '0;
        m_read_i  = 1'b0;
        m_write_i = 1'b0;
        gpio_in_i = '0;
        @(posedge rst_n_i);
        @(negedge clk);
        check_value("reset_outputs", '0, gpio_out_o | {30'd0, m_stall_o, irq_o});
        @(posedge clk);
        #1;
        // full-word writes come first, so every word read back is defined.
        for (int i = 0; i < 32; i++) begin
            if (i < 16) ram_idx[i] = 10'($urandom);
            val = $urandom;
            be  = (i < 16) ? 4'hf : 4'($urandom_range(1, 14));
            do_access(ram_addr(ram_idx[i % 16]), val, be, 1'b1);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) shadow[ram_idx[i % 16]][8*b +: 8] = val[8*b +: 8];
            end
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(ram_addr(ram_idx[i]));
            check_value("ram_read", shadow[ram_idx[i]], rd);
        end
        // one read accepted per cycle while the previous one returns.
        for (int i = 0; i <= 16; i++) begin
            m_addr_i = ram_addr(ram_idx[i % 16]);
            m_read_i = (i < 16);
            @(negedge clk);
            if (i > 0) check_value("ram_back_to_back", shadow[ram_idx[i-1]], m_rdata_o);
            @(posedge clk);
            #1;
        end
        bus_read(slave_addr(4'h7, 28'h40));
        check_value("unmapped_read", '0, rd);
        check_value("unmapped_stall", '0, stalls);
        do_access(slave_addr(4'h9, 28'({ram_idx[0], 2'b00})), ~shadow[ram_idx[0]], 4'hf, 1'b1);
        bus_read(ram_addr(ram_idx[0]));
        check_value("unmapped_write", shadow[ram_idx[0]], rd);
        // a write to the boot ROM completes at once and leaves the pattern alone.
        do_access(slave_addr(`SEL_ROM, 28'({8'd255, 2'b00})), $urandom, 4'hf, 1'b1);
        check_value("rom_write_stall", '0, stalls);
        for (int i = 0; i < 6; i++) begin
            lo = (i == 0) ? 16'd255 : 16'($urandom_range(0, 255));
            bus_read(slave_addr(`SEL_ROM, 28'({lo[7:0], 2'b00})));
            check_value("rom_stall_cycles", `ROM_WAIT, stalls);
            check_value("rom_data", {~lo, lo}, rd);
        end
        val = $urandom;
        do_access(slave_addr(`SEL_GPIO, 28'h0), val, 4'hf, 1'b1);
        @(negedge clk);
        check_value("gpio_out", val, gpio_out_o);
        @(posedge clk);
        #1;
        gpio_in_i = $urandom;
        repeat (3) @(posedge clk);
        #1;
        bus_read(slave_addr(`SEL_GPIO, 28'h4));
        check_value("gpio_in", gpio_in_i, rd);
        val = $urandom & 32'h0fff_ffff;
        do_access(slave_addr(`SEL_TICK, 28'h0), val, 4'hf, 1'b1);
        t_load = accept_cycle;
        repeat (5) @(posedge clk);
        #1;
        bus_read(slave_addr(`SEL_TICK, 28'h0));
        // the loaded value is counted up once per cycle between the two edges.
        check_value("tick_count", val + 32'(accept_cycle - t_load - 1), rd);
        do_access(slave_addr(`SEL_TICK, 28'h4), 32'ha000_0000, 4'hf, 1'b1);
        do_access(slave_addr(`SEL_TICK, 28'h0), 32'ha000_0000 - IRQ_DIST, 4'hf, 1'b1);
        waited = 0;
        @(negedge clk);
        while (!irq_o && waited < IRQ_DIST + 1) begin
            waited++;
            @(negedge clk);
        end
        check_value("irq_rise", 1, 32'(irq_o));
        @(posedge clk);
        #1;
        bus_read(slave_addr(`SEL_TICK, 28'h8));
        check_value("irq_status", 1, rd);
        do_access(slave_addr(`SEL_TICK, 28'h8), '0, 4'hf, 1'b1);
        @(negedge clk);
        check_value("irq_clear", 0, 32'(irq_o));
        repeat (2) @(posedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule
